//--- compile.f
+incdir+tests
source/gb_ctrl_pkg.sv
source/opcode_decoder.sv
source/cycle_sequencer.sv
source/gb_control.sv
tests/tb_gb_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_gb_control \
    -f compile.f -o sim_gb_control > build.log 2>&1 \
    && ./obj_dir/sim_gb_control > sim.log 2>&1 \
    || { echo "Build or run failed, see build.log and sim.log"; exit 1; }
grep -qx "TESTBENCH PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- tests/tb_expect.svh
`ifndef TB_EXPECT_SVH
`define TB_EXPECT_SVH

// Instruction class straight from the opcode map
function automatic instr_class_e exp_class(input logic [7:0] op);
    case (op) inside
        8'h00: return CLS_NOP;
        8'h10: return CLS_STOP;
        8'h76: return CLS_HALT;
        8'h01, 8'h11, 8'h21, 8'h31: return CLS_LD16_IMM;
        8'h18, 8'h20, 8'h28, 8'h30, 8'h38: return CLS_JR;
        8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA: return CLS_JP;
        8'hCD, 8'hC4, 8'hCC, 8'hD4, 8'hDC: return CLS_CALL;
        8'hC5, 8'hD5, 8'hE5, 8'hF5: return CLS_PUSH;
        8'hC1, 8'hD1, 8'hE1, 8'hF1: return CLS_POP;
        [8'h40:8'h7F]: return (op[2:0] == 3'd6 || op[5:3] == 3'd6) ? CLS_INVALID : CLS_LD_REG;
        [8'h80:8'hBF]: return (op[2:0] == 3'd6) ? CLS_INVALID : CLS_ALU_REG;
        default: return CLS_INVALID;
    endcase
endfunction

function automatic logic exp_taken(input logic [7:0] op, input cpu_flags_t f);
    if (op == 8'h18 || op == 8'hC3 || op == 8'hCD)
        return 1'b1;
    case (op[4:3])
        2'd0: return !f.z;
        2'd1: return f.z;
        2'd2: return !f.c;
        default: return f.c;
    endcase
endfunction

// Index of the last machine cycle
function automatic int exp_last(input logic [7:0] op, input cpu_flags_t f);
    case (exp_class(op))
        CLS_LD16_IMM, CLS_POP: return 2;
        CLS_PUSH: return 3;
        CLS_JR: return exp_taken(op, f) ? 2 : 1;
        CLS_JP: return exp_taken(op, f) ? 3 : 2;
        CLS_CALL: return exp_taken(op, f) ? 5 : 2;
        default: return 0;
    endcase
endfunction

function automatic bus_op_e exp_bus(input logic [7:0] op, input cpu_flags_t f, input int m);
    instr_class_e cls;
    cls = exp_class(op);
    if (m >= exp_last(op, f))
        return BUS_FETCH;
    if ((cls == CLS_JP || cls == CLS_CALL) && m == 2)
        return BUS_IDLE;
    if ((cls == CLS_CALL && m >= 3) || (cls == CLS_PUSH && m >= 1))
        return BUS_WRITE;
    return BUS_READ; // Operand reads
endfunction

function automatic ab_src_e exp_ab(input logic [7:0] op, input cpu_flags_t f, input int m);
    instr_class_e cls;
    cls = exp_class(op);
    if (m >= exp_last(op, f))
        return AB_PC;
    if ((cls == CLS_CALL && m >= 3) || (cls == CLS_PUSH && m >= 1) || cls == CLS_POP)
        return AB_SP;
    return AB_PC;
endfunction

function automatic ct_op_e exp_ct(input logic [7:0] op, input cpu_flags_t f, input int m);
    instr_class_e cls;
    cls = exp_class(op);
    if (m >= exp_last(op, f))
        return CT_INC;
    if ((cls == CLS_CALL && (m == 2 || m == 3)) || (cls == CLS_PUSH && m >= 1))
        return CT_DEC; // SP walks down
    return CT_INC;
endfunction

`endif

//--- tests/tb_gb_control.sv
`timescale 1ns/1ps

module tb_gb_control;
    import gb_ctrl_pkg::*;

    logic                clk = 1'b0;
    logic                rst;
    logic [OPCODE_W-1:0] opcode_early;
    logic [MCYCLE_W-1:0] m_cycle;
    cpu_flags_t          flags;
    ctrl_word_t          ctrl;
    pc_ctrl_t            pc_ctrl;
    logic                next;
    logic                stop;
    logic                halt;

    int         errors = 0;
    int         checks = 0;
    int         issued = 0; // Instructions sent so far
    int         cycles = 0;
    logic [7:0] cur_op;

    `include "tb_expect.svh"

    gb_control i_gb_control (
        .clk          (clk),
        .rst          (rst),
        .opcode_early (opcode_early),
        .m_cycle      (m_cycle),
        .flags        (flags),
        .ctrl         (ctrl),
        .pc_ctrl      (pc_ctrl),
        .next         (next),
        .stop         (stop),
        .halt         (halt)
    );

    always #20 clk = ~clk;

    // Limit grows with the number of instructions issued
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 20 * issued + 100) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [7:0] exp_v, input logic [7:0] act);
        checks++;
        assert (act === exp_v)
        else begin
            errors++;
            $display("** Error: %s expected 0x%02h, actual 0x%02h (opcode 0x%02h, m_cycle %0d)",
                     name, exp_v, act, cur_op, m_cycle);
        end
    endtask

    task automatic check_cycle(input logic [7:0] op, input cpu_flags_t f, input int m);
        instr_class_e cls;
        int           last;
        logic         tk;
        logic         af;
        logic         e_fwe;
        pc_ctrl_t     e_pc;
        cls    = exp_class(op);
        last   = exp_last(op, f);
        tk     = exp_taken(op, f);
        af     = (op[5:4] == 2'b11);
        cur_op = op;
        e_pc.pc_we    = tk && ((cls == CLS_JP && m == 2) || (cls == CLS_CALL && m == 4));
        e_pc.pc_src   = e_pc.pc_we ? PC_TEMP : PC_INCR;
        e_pc.pc_b_sel = m[0];
        e_pc.pc_jr    = tk && cls == CLS_JR && m == 1;
        e_fwe = (cls == CLS_ALU_REG && m == 0) || (cls == CLS_POP && af && m == 2);
        check_val("next", 8'(m < last), 8'(next));
        check_val("stop", 8'(m == 0 && (cls == CLS_STOP || cls == CLS_INVALID)), 8'(stop));
        check_val("halt", 8'(m == 0 && (cls == CLS_HALT || cls == CLS_INVALID)), 8'(halt));
        check_val("pc_ctrl", 8'(e_pc), 8'(pc_ctrl));
        check_val("bus_op", 8'(exp_bus(op, f, m)), 8'(ctrl.bus_op));
        check_val("ab_src", 8'(exp_ab(op, f, m)), 8'(ctrl.ab_src));
        check_val("ct_op", 8'(exp_ct(op, f, m)), 8'(ctrl.ct_op));
        check_val("flags_we", 8'(e_fwe), 8'(ctrl.flags_we));
        if ((cls == CLS_LD_REG || cls == CLS_ALU_REG) && m == 0)
            check_val("rf_rd_sel", 8'(op[2:0]), 8'(ctrl.rf_rd_sel));
        if (cls == CLS_LD_REG && m == 0) begin
            check_val("rf_wr_sel", 8'(op[5:3]), 8'(ctrl.rf_wr_sel));
            check_val("alu_dst", 8'(DST_REG), 8'(ctrl.alu_dst));
        end
        if (cls == CLS_ALU_REG && m == 0)
            check_val("alu_dst", 8'(DST_ACC), 8'(ctrl.alu_dst));
        if (cls == CLS_LD16_IMM && m == 2)
            check_val("rf_wr_sel", 8'({op[5:4], 1'b0}), 8'(ctrl.rf_wr_sel));
        if (cls == CLS_PUSH && m == 2) begin
            if (af)
                check_val("db_src", 8'h01, 8'(ctrl.db_src)); // Flags byte
            else
                check_val("rf_rd_sel", 8'({op[5:4], 1'b1}), 8'(ctrl.rf_rd_sel));
        end
        if (cls == CLS_POP && m == 2) begin
            if (af)
                check_val("alu_dst", 8'(DST_FLAGS_ONLY), 8'(ctrl.alu_dst));
            else
                check_val("rf_wr_sel", 8'({op[5:4], 1'b1}), 8'(ctrl.rf_wr_sel));
        end
    endtask

    function automatic cpu_flags_t rand_flags();
        return cpu_flags_t'(2'($urandom_range(0, 3)));
    endfunction

    // Opcode one edge early, then m_cycle steps until the last cycle
    task automatic run_instr(input logic [7:0] op, input cpu_flags_t f);
        int   last;
        int   m;
        logic done;
        last = exp_last(op, f);
        @(posedge clk);
        opcode_early <= op;
        flags        <= f;
        m_cycle      <= 3'd0;
        issued++;
        m    = 0;
        done = 1'b0;
        @(posedge clk);
        while (!done) begin
            @(negedge clk);
            check_cycle(op, f, m);
            if (next !== 1'b1 || m >= last) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                m++;
                m_cycle <= 3'(m);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        @(negedge clk);
        check_cycle(8'h00, flags, 0);
    endtask

    task automatic test_one_cycle();
        logic [2:0] dst;
        logic [2:0] src;
        logic [2:0] alu;
        for (int i = 0; i < 12; i++) begin
            dst = 3'($urandom_range(0, 7));
            src = 3'($urandom_range(0, 7));
            alu = 3'($urandom_range(0, 7));
            if (dst == 3'd6)
                dst = 3'd7;
            if (src == 3'd6)
                src = 3'd0; // Skip the (HL) column
            run_instr({2'b01, dst, src}, rand_flags());
            run_instr({2'b10, alu, src}, rand_flags());
        end
    endtask

    task automatic test_branches();
        logic [7:0] ops [15] = '{8'h18, 8'h20, 8'h28, 8'h30, 8'h38,
                                 8'hC3, 8'hC2, 8'hCA, 8'hD2, 8'hDA,
                                 8'hCD, 8'hC4, 8'hCC, 8'hD4, 8'hDC};
        for (int i = 0; i < 15; i++) begin
            for (int f = 0; f < 4; f++)
                run_instr(ops[i], cpu_flags_t'(2'(f)));
            run_instr(ops[i], rand_flags());
        end
    endtask

    task automatic test_stack();
        logic [7:0] ops [12] = '{8'hC5, 8'hD5, 8'hE5, 8'hF5, 8'hC1, 8'hD1,
                                 8'hE1, 8'hF1, 8'h01, 8'h11, 8'h21, 8'h31};
        for (int i = 0; i < 12; i++)
            run_instr(ops[i], rand_flags());
    endtask

    task automatic test_halt_stop();
        logic [7:0] ops [9] = '{8'h76, 8'h10, 8'hD3, 8'hCB, 8'hE0,
                                8'hE2, 8'h36, 8'h86, 8'h46};
        logic [7:0] any_ops [4] = '{8'h00, 8'h76, 8'hCD, 8'h80};
        for (int i = 0; i < 9; i++)
            run_instr(ops[i], rand_flags());
        // m_cycle beyond any sequence
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            opcode_early <= any_ops[i];
            m_cycle      <= 3'd6;
            issued++;
            cur_op = any_ops[i];
            for (int m = 6; m < 8; m++) begin
                @(posedge clk);
                m_cycle <= 3'(m);
                @(negedge clk);
                check_val("stop", 8'h01, 8'(stop));
                check_val("halt", 8'h01, 8'(halt));
                check_val("next", 8'h01, 8'(next));
            end
        end
    endtask

    task automatic test_latency();
        @(posedge clk);
        opcode_early <= 8'hC3;
        flags        <= '0;
        m_cycle      <= 3'd0;
        issued++;
        @(posedge clk);
        opcode_early <= 8'h76; // Only taken at the following edge
        @(negedge clk);
        check_cycle(8'hC3, '0, 0);
        @(posedge clk);
        @(negedge clk);
        check_cycle(8'h76, '0, 0);
    endtask

    initial begin
        void'($urandom(32'h6c47_89cd));
        rst          = 1'b1;
        opcode_early = 8'hD3; // Not NOP, so only reset can load NOP
        m_cycle      = 3'd0;
        flags        = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_one_cycle();
        test_branches();
        test_stack();
        test_halt_stop();
        test_latency();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- source/gb_control.sv
`timescale 1ns/1ps

module gb_control (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [gb_ctrl_pkg::OPCODE_W-1:0] opcode_early,
    input  logic [gb_ctrl_pkg::MCYCLE_W-1:0] m_cycle,
    input  gb_ctrl_pkg::cpu_flags_t          flags,
    output gb_ctrl_pkg::ctrl_word_t          ctrl,
    output gb_ctrl_pkg::pc_ctrl_t            pc_ctrl,
    output logic                             next,
    output logic                             stop,
    output logic                             halt
);
    import gb_ctrl_pkg::*;

    decoded_t dec; // Registered decode, one clock after opcode_early

    opcode_decoder i_opcode_decoder (
        .clk          (clk),
        .rst          (rst),
        .opcode_early (opcode_early),
        .dec          (dec)
    );

    cycle_sequencer i_cycle_sequencer (
        .dec     (dec),
        .m_cycle (m_cycle),
        .flags   (flags),
        .ctrl    (ctrl),
        .pc_ctrl (pc_ctrl),
        .next    (next),
        .stop    (stop),
        .halt    (halt)
    );

endmodule

//--- source/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer (
    input  gb_ctrl_pkg::decoded_t            dec,
    input  logic [gb_ctrl_pkg::MCYCLE_W-1:0] m_cycle,
    input  gb_ctrl_pkg::cpu_flags_t          flags,
    output gb_ctrl_pkg::ctrl_word_t          ctrl,
    output gb_ctrl_pkg::pc_ctrl_t            pc_ctrl,
    output logic                             next,
    output logic                             stop,
    output logic                             halt
);
    import gb_ctrl_pkg::*;

    logic uncond;
    logic cond_met;
    logic taken;
    logic end_cycle;

    ////////////////////////////////////////////////////////////
    // Branch condition
    ////////////////////////////////////////////////////////////

    always_comb begin
        // JR uses bit 5 for the conditional forms, JP and CALL use bit 0
        uncond = (dec.cls == CLS_JR) ? !dec.opcode[5] : dec.opcode[0];
        case (cond_e'(dec.opcode[4:3]))
            COND_NZ: cond_met = !flags.z;
            COND_Z:  cond_met = flags.z;
            COND_NC: cond_met = !flags.c;
            default: cond_met = flags.c;
        endcase
        taken = uncond || cond_met;
    end

    ////////////////////////////////////////////////////////////
    // Per-cycle overrides
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl             = dec.word;
        pc_ctrl.pc_src   = PC_INCR;
        pc_ctrl.pc_we    = 1'b0;
        pc_ctrl.pc_b_sel = m_cycle[0];
        pc_ctrl.pc_jr    = 1'b0;
        stop             = 1'b0;
        halt             = 1'b0;
        next             = 1'b0;
        end_cycle        = 1'b1; // Past the sequence means end word

        if (m_cycle > 3'd5) begin
            // No instruction runs this long
            stop = 1'b1;
            halt = 1'b1;
            next = 1'b1;
        end else begin
            case (dec.cls)
                CLS_HALT:
                    halt = (m_cycle == 3'd0);
                CLS_STOP:
                    stop = (m_cycle == 3'd0);
                CLS_INVALID: begin
                    stop = (m_cycle == 3'd0);
                    halt = (m_cycle == 3'd0);
                end
                CLS_LD16_IMM: begin
                    if (m_cycle < 3'd2)
                        end_cycle = 1'b0;
                    else if (m_cycle == 3'd2)
                        ctrl.rf_wr_sel = pair_high(dec.opcode);
                end
                CLS_JR: begin
                    if (m_cycle == 3'd0) begin
                        end_cycle = 1'b0;
                    end else if (m_cycle == 3'd1 && taken) begin
                        pc_ctrl.pc_jr = 1'b1;
                        end_cycle     = 1'b0;
                    end
                end
                CLS_JP: begin
                    if (m_cycle < 3'd2) begin
                        end_cycle = 1'b0;
                    end else if (m_cycle == 3'd2 && taken) begin
                        pc_ctrl.pc_src = PC_TEMP;
                        pc_ctrl.pc_we  = 1'b1;
                        ctrl.bus_op    = BUS_IDLE;
                        end_cycle      = 1'b0;
                    end
                end
                CLS_CALL: begin
                    case (m_cycle)
                        3'd0, 3'd1:
                            end_cycle = 1'b0;
                        3'd2: begin
                            if (taken) begin
                                ctrl.bus_op = BUS_IDLE; // SP pre-decrement
                                ctrl.ct_op  = CT_DEC;
                                end_cycle   = 1'b0;
                            end
                        end
                        3'd3: begin
                            ctrl.bus_op = BUS_WRITE; // Return address high
                            ctrl.ab_src = AB_SP;
                            ctrl.ct_op  = CT_DEC;
                            end_cycle   = 1'b0;
                        end
                        3'd4: begin
                            ctrl.bus_op    = BUS_WRITE;
                            ctrl.ab_src    = AB_SP;
                            pc_ctrl.pc_src = PC_TEMP;
                            pc_ctrl.pc_we  = 1'b1;
                            end_cycle      = 1'b0;
                        end
                        default: ;
                    endcase
                end
                CLS_PUSH: begin
                    if (m_cycle == 3'd0) begin
                        end_cycle = 1'b0;
                    end else if (m_cycle < 3'd3) begin
                        ctrl.bus_op = BUS_WRITE;
                        ctrl.ab_src = AB_SP;
                        ctrl.ct_op  = CT_DEC;
                        end_cycle   = 1'b0;
                        if (m_cycle == 3'd2) begin
                            if (dec.opcode[5:4] == 2'b11)
                                ctrl.db_src = DB_SRC_FLAGS; // F goes out as the low byte
                            else
                                ctrl.rf_rd_sel = pair_low(dec.opcode);
                        end
                    end
                end
                CLS_POP: begin
                    if (m_cycle < 3'd2) begin
                        ctrl.bus_op = BUS_READ;
                        ctrl.ab_src = AB_SP;
                        end_cycle   = 1'b0;
                    end else if (m_cycle == 3'd2) begin
                        if (dec.opcode[5:4] == 2'b11) begin
                            ctrl.alu_dst  = DST_FLAGS_ONLY;
                            ctrl.flags_we = 1'b1;
                        end else begin
                            ctrl.rf_wr_sel = pair_low(dec.opcode);
                        end
                    end
                end
                default: ; // NOP, LD r,r' and ALU end at cycle 0
            endcase

            if (end_cycle) begin
                ctrl.bus_op = BUS_FETCH; // Overlap fetch of the next opcode
                ctrl.ab_src = AB_PC;
                ctrl.ct_op  = CT_INC;
            end
            next = !end_cycle;
        end
    end

endmodule

//--- source/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [gb_ctrl_pkg::OPCODE_W-1:0] opcode_early,
    output gb_ctrl_pkg::decoded_t           dec
);
    import gb_ctrl_pkg::*;

    localparam logic [OPCODE_W-1:0] OP_NOP  = 8'h00;
    localparam logic [OPCODE_W-1:0] OP_STOP = 8'h10;
    localparam logic [OPCODE_W-1:0] OP_JR   = 8'h18;
    localparam logic [OPCODE_W-1:0] OP_HALT = 8'h76;
    localparam logic [OPCODE_W-1:0] OP_JP   = 8'hC3;
    localparam logic [OPCODE_W-1:0] OP_CALL = 8'hCD;

    instr_class_e cls_early;
    ctrl_word_t   word_early;

    ////////////////////////////////////////////////////////////
    // Classification by bit fields
    ////////////////////////////////////////////////////////////

    function automatic instr_class_e classify(input logic [OPCODE_W-1:0] op);
        instr_class_e cls;
        cls = CLS_INVALID;
        case (op[7:6])
            2'b00: begin
                if (op == OP_NOP)
                    cls = CLS_NOP;
                else if (op == OP_STOP)
                    cls = CLS_STOP;
                else if (op[3:0] == 4'h1)
                    cls = CLS_LD16_IMM;
                else if (op == OP_JR || (op[5] && op[2:0] == 3'b000))
                    cls = CLS_JR; // 20/28/30/38
            end
            2'b01: begin
                if (op == OP_HALT)
                    cls = CLS_HALT;
                else if (op[2:0] != 3'd6 && op[5:3] != 3'd6)
                    cls = CLS_LD_REG;
            end
            2'b10: begin
                if (op[2:0] != 3'd6)
                    cls = CLS_ALU_REG;
            end
            default: begin
                if (op == OP_JP || (!op[5] && op[2:0] == 3'b010))
                    cls = CLS_JP;
                else if (op == OP_CALL || (!op[5] && op[2:0] == 3'b100))
                    cls = CLS_CALL;
                else if (op[3:0] == 4'h5)
                    cls = CLS_PUSH;
                else if (op[3:0] == 4'h1)
                    cls = CLS_POP;
            end
        endcase
        return cls;
    endfunction

    ////////////////////////////////////////////////////////////
    // Cycle-zero control word
    ////////////////////////////////////////////////////////////

    function automatic ctrl_word_t zero_word(input logic [OPCODE_W-1:0] op,
                                             input instr_class_e cls);
        ctrl_word_t w;
        w.alu_src_a = ALU_A_ACC;
        w.alu_src_b = ALU_B_ZERO;
        w.alu_op    = ALU_OP_OR;
        w.alu_dst   = DST_NONE;
        w.rf_rd_sel = REG_A;
        w.rf_wr_sel = REG_A;
        w.bus_op    = BUS_FETCH;
        w.db_src    = DB_SRC_REG;
        w.ab_src    = AB_PC;
        w.ct_op     = CT_INC;
        w.flags_we  = 1'b0;
        case (cls)
            CLS_LD_REG: begin
                w.alu_src_a = ALU_A_REG; // r' through the ALU unchanged
                w.alu_dst   = DST_REG;
                w.rf_rd_sel = reg_sel_e'(op[2:0]);
                w.rf_wr_sel = reg_sel_e'(op[5:3]);
            end
            CLS_ALU_REG: begin
                w.alu_src_b = ALU_B_REG;
                w.alu_op    = op[5:3];
                w.alu_dst   = DST_ACC;
                w.rf_rd_sel = reg_sel_e'(op[2:0]);
                w.flags_we  = 1'b1;
            end
            CLS_LD16_IMM: begin
                w.bus_op    = BUS_READ;
                w.rf_wr_sel = pair_low(op); // Low byte arrives first
            end
            CLS_PUSH: begin
                w.bus_op    = BUS_READ;
                w.rf_rd_sel = (op[5:4] == 2'b11) ? REG_A : pair_high(op);
            end
            CLS_POP: begin
                w.bus_op    = BUS_READ;
                w.rf_wr_sel = (op[5:4] == 2'b11) ? REG_A : pair_high(op);
            end
            CLS_JR, CLS_JP, CLS_CALL:
                w.bus_op = BUS_READ; // Operand fetch from PC
            default: ;
        endcase
        return w;
    endfunction

    always_comb begin
        cls_early  = classify(opcode_early);
        word_early = zero_word(opcode_early, cls_early);
    end

    // Opcode is one clock early, so the decode lines up with m_cycle 0
    always_ff @(posedge clk) begin
        if (rst) begin
            dec.opcode <= OP_NOP;
            dec.cls    <= CLS_NOP;
            dec.word   <= zero_word(OP_NOP, CLS_NOP);
        end else begin
            dec.opcode <= opcode_early;
            dec.cls    <= cls_early;
            dec.word   <= word_early;
        end
    end

endmodule

//--- source/gb_ctrl_pkg.sv
package gb_ctrl_pkg;

    localparam int OPCODE_W = 8;
    localparam int MCYCLE_W = 3;

    ////////////////////////////////////////////////////////////
    // Field encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        CLS_NOP, CLS_LD_REG, CLS_ALU_REG, CLS_LD16_IMM,
        CLS_JR, CLS_JP, CLS_CALL, CLS_PUSH,
        CLS_POP, CLS_HALT, CLS_STOP, CLS_INVALID
    } instr_class_e;

    typedef enum logic [1:0] {BUS_IDLE, BUS_FETCH, BUS_WRITE, BUS_READ} bus_op_e;
    typedef enum logic [1:0] {AB_PC, AB_TEMP, AB_HL, AB_SP} ab_src_e;
    typedef enum logic [1:0] {CT_KEEP, CT_INC, CT_DEC} ct_op_e;
    typedef enum logic [1:0] {PC_INCR, PC_VECTOR, PC_TEMP} pc_src_e;
    typedef enum logic [1:0] {DST_ACC, DST_FLAGS_ONLY, DST_REG, DST_NONE} alu_dst_e;

    // Hardware register order of the instruction set
    typedef enum logic [2:0] {
        REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_F, REG_A
    } reg_sel_e;

    typedef enum logic [1:0] {COND_NZ, COND_Z, COND_NC, COND_C} cond_e; // opcode[4:3]

    // ALU operand and data bus selects
    localparam logic [1:0] ALU_A_ACC  = 2'b00;
    localparam logic [1:0] ALU_A_REG  = 2'b10;
    localparam logic [2:0] ALU_B_REG  = 3'b010;
    localparam logic [2:0] ALU_B_ZERO = 3'b011;
    localparam logic [2:0] ALU_OP_OR  = 3'b110; // OR with zero passes operand A
    localparam logic [1:0] DB_SRC_REG   = 2'b00;
    localparam logic [1:0] DB_SRC_FLAGS = 2'b01;

    ////////////////////////////////////////////////////////////
    // Control structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0] alu_src_a;
        logic [2:0] alu_src_b;
        logic [2:0] alu_op;
        alu_dst_e   alu_dst;
        reg_sel_e   rf_rd_sel;
        reg_sel_e   rf_wr_sel;
        bus_op_e    bus_op;
        logic [1:0] db_src;
        ab_src_e    ab_src;
        ct_op_e     ct_op;
        logic       flags_we;
    } ctrl_word_t;

    typedef struct packed {
        pc_src_e pc_src;
        logic    pc_we;
        logic    pc_b_sel;
        logic    pc_jr;
    } pc_ctrl_t;

    typedef struct packed {
        logic z;
        logic c;
    } cpu_flags_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        instr_class_e        cls;
        ctrl_word_t          word;
    } decoded_t;

    // Register pair halves from opcode[5:4]
    function automatic reg_sel_e pair_high(input logic [OPCODE_W-1:0] op);
        return reg_sel_e'({op[5:4], 1'b0});
    endfunction

    function automatic reg_sel_e pair_low(input logic [OPCODE_W-1:0] op);
        return reg_sel_e'({op[5:4], 1'b1});
    endfunction

endpackage
